//--- tmu_pkg.sv
// texture mapping unit shared widths, register map, state codes and pixel format.
package tmu_pkg;

	// fixed point is 1 sign, 11 integer and 6 fractional bits.
	localparam int FP_W = 18;
	localparam int FP_FRAC = 6;
	localparam int DIFF_W = 17;
	localparam int PIX_W = 12;
	localparam int RES_W = 11;
	localparam int ADR_W = 24;
	localparam int BRIGHT_W = 6;
	localparam int CSR_AW = 4;
	localparam int DIV_STEPS = 17;

	// register indices.
	localparam logic [CSR_AW-1:0] REG_CTRL = 4'd0;
	localparam logic [CSR_AW-1:0] REG_BRIGHT = 4'd1;
	localparam logic [CSR_AW-1:0] REG_CKEY = 4'd2;
	localparam logic [CSR_AW-1:0] REG_TEX_FBUF = 4'd3;
	localparam logic [CSR_AW-1:0] REG_TEX_HRES = 4'd4;
	localparam logic [CSR_AW-1:0] REG_TEX_HMASK = 4'd5;
	localparam logic [CSR_AW-1:0] REG_TEX_VMASK = 4'd6;
	localparam logic [CSR_AW-1:0] REG_DST_FBUF = 4'd7;
	localparam logic [CSR_AW-1:0] REG_DST_HRES = 4'd8;
	localparam logic [CSR_AW-1:0] REG_DST_X = 4'd9;
	localparam logic [CSR_AW-1:0] REG_DST_Y = 4'd10;
	localparam logic [CSR_AW-1:0] REG_SPAN_W = 4'd11;
	localparam logic [CSR_AW-1:0] REG_TS_X = 4'd12;
	localparam logic [CSR_AW-1:0] REG_TS_Y = 4'd13;
	localparam logic [CSR_AW-1:0] REG_TE_X = 4'd14;
	localparam logic [CSR_AW-1:0] REG_TE_Y = 4'd15;

	// top level and pixel output FSM states.
	localparam logic TOP_IDLE = 1'b0;
	localparam logic TOP_PROCESS = 1'b1;
	localparam logic [1:0] PIX_IDLE = 2'd0;
	localparam logic [1:0] PIX_READ = 2'd1;
	localparam logic [1:0] PIX_WRITE = 2'd2;

	// rgb565 pixel, raw word for the chroma key.
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] r;
			logic [5:0] g;
			logic [4:0] b;
		} rgb;
	} pixel_t;

endpackage

//--- tmu_ctlif.sv
// texture mapping unit control registers with readback, start pulse and interrupt.
`timescale 1ns/1ps

module tmu_ctlif (
	input  logic                                sys_clk,
	input  logic                                sys_rst,
	input  logic [tmu_pkg::CSR_AW-1:0]          csr_a_i,
	input  logic                                csr_we_i,
	input  logic [31:0]                         csr_di_i,
	output logic [31:0]                         csr_do_o,
	output logic                                irq_o,
	output logic                                start_o,
	input  logic                                busy_i,
	output logic [tmu_pkg::BRIGHT_W-1:0]        brightness_o,
	output logic                                chroma_key_en_o,
	output tmu_pkg::pixel_t                     chroma_key_o,
	output logic [tmu_pkg::ADR_W-1:0]           tex_fbuf_o,
	output logic [tmu_pkg::RES_W-1:0]           tex_hres_o,
	output logic [tmu_pkg::FP_W-1:0]            tex_hmask_o,
	output logic [tmu_pkg::FP_W-1:0]            tex_vmask_o,
	output logic [tmu_pkg::ADR_W-1:0]           dst_fbuf_o,
	output logic [tmu_pkg::RES_W-1:0]           dst_hres_o,
	output logic signed [tmu_pkg::PIX_W-1:0]    dst_x_o,
	output logic signed [tmu_pkg::PIX_W-1:0]    dst_y_o,
	output logic [tmu_pkg::RES_W-1:0]           span_w_o,
	output logic signed [tmu_pkg::FP_W-1:0]     ts_x_o,
	output logic signed [tmu_pkg::FP_W-1:0]     ts_y_o,
	output logic signed [tmu_pkg::FP_W-1:0]     te_x_o,
	output logic signed [tmu_pkg::FP_W-1:0]     te_y_o
);
	import tmu_pkg::*;

	logic busy_d;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brightness_o <= '0;
			chroma_key_en_o <= 1'b0;
			chroma_key_o <= '0;
			tex_fbuf_o <= '0;
			tex_hres_o <= '0;
			tex_hmask_o <= '0;
			tex_vmask_o <= '0;
			dst_fbuf_o <= '0;
			dst_hres_o <= '0;
			dst_x_o <= '0;
			dst_y_o <= '0;
			span_w_o <= '0;
			ts_x_o <= '0;
			ts_y_o <= '0;
			te_x_o <= '0;
			te_y_o <= '0;
			start_o <= 1'b0;
			busy_d <= 1'b0;
			irq_o <= 1'b0;
		end else begin
			// a start request is ignored while a span is running.
			start_o <= csr_we_i & (csr_a_i == REG_CTRL) & csr_di_i[0] & ~busy_i;
			busy_d <= busy_i;
			irq_o <= busy_d & ~busy_i;
			if (csr_we_i) begin
				case (csr_a_i)
					REG_CTRL: chroma_key_en_o <= csr_di_i[1];
					REG_BRIGHT: brightness_o <= csr_di_i[BRIGHT_W-1:0];
					REG_CKEY: chroma_key_o.raw <= csr_di_i[15:0];
					REG_TEX_FBUF: tex_fbuf_o <= csr_di_i[ADR_W-1:0];
					REG_TEX_HRES: tex_hres_o <= csr_di_i[RES_W-1:0];
					REG_TEX_HMASK: tex_hmask_o <= csr_di_i[FP_W-1:0];
					REG_TEX_VMASK: tex_vmask_o <= csr_di_i[FP_W-1:0];
					REG_DST_FBUF: dst_fbuf_o <= csr_di_i[ADR_W-1:0];
					REG_DST_HRES: dst_hres_o <= csr_di_i[RES_W-1:0];
					REG_DST_X: dst_x_o <= csr_di_i[PIX_W-1:0];
					REG_DST_Y: dst_y_o <= csr_di_i[PIX_W-1:0];
					REG_SPAN_W: span_w_o <= csr_di_i[RES_W-1:0];
					REG_TS_X: ts_x_o <= csr_di_i[FP_W-1:0];
					REG_TS_Y: ts_y_o <= csr_di_i[FP_W-1:0];
					REG_TE_X: te_x_o <= csr_di_i[FP_W-1:0];
					default: te_y_o <= csr_di_i[FP_W-1:0];
				endcase
			end
		end
	end

	// readback, signed fields come back sign extended.
	always_ff @(posedge sys_clk) begin
		case (csr_a_i)
			REG_CTRL: csr_do_o <= {30'd0, chroma_key_en_o, busy_i};
			REG_BRIGHT: csr_do_o <= 32'(brightness_o);
			REG_CKEY: csr_do_o <= {16'd0, chroma_key_o.raw};
			REG_TEX_FBUF: csr_do_o <= 32'(tex_fbuf_o);
			REG_TEX_HRES: csr_do_o <= 32'(tex_hres_o);
			REG_TEX_HMASK: csr_do_o <= 32'(tex_hmask_o);
			REG_TEX_VMASK: csr_do_o <= 32'(tex_vmask_o);
			REG_DST_FBUF: csr_do_o <= 32'(dst_fbuf_o);
			REG_DST_HRES: csr_do_o <= 32'(dst_hres_o);
			REG_DST_X: csr_do_o <= 32'(dst_x_o);
			REG_DST_Y: csr_do_o <= 32'(dst_y_o);
			REG_SPAN_W: csr_do_o <= 32'(span_w_o);
			REG_TS_X: csr_do_o <= 32'(ts_x_o);
			REG_TS_Y: csr_do_o <= 32'(ts_y_o);
			REG_TE_X: csr_do_o <= 32'(te_x_o);
			default: csr_do_o <= 32'(te_y_o);
		endcase
	end

endmodule

//--- tmu_hdiv.sv
// horizontal divider, splits the texture deltas over the span width.
`timescale 1ns/1ps

module tmu_hdiv (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic                             start_i,
	input  logic signed [tmu_pkg::FP_W-1:0]  ts_x_i,
	input  logic signed [tmu_pkg::FP_W-1:0]  ts_y_i,
	input  logic signed [tmu_pkg::FP_W-1:0]  te_x_i,
	input  logic signed [tmu_pkg::FP_W-1:0]  te_y_i,
	input  logic [tmu_pkg::RES_W-1:0]        span_w_i,
	output logic                             busy_o,
	output logic                             pipe_stb_o,
	input  logic                             pipe_ack_i,
	output logic signed [tmu_pkg::FP_W-1:0]  ts_x_o,
	output logic signed [tmu_pkg::FP_W-1:0]  ts_y_o,
	output logic                             x_pos_o,
	output logic [tmu_pkg::DIFF_W-1:0]       x_q_o,
	output logic [tmu_pkg::DIFF_W-1:0]       x_r_o,
	output logic                             y_pos_o,
	output logic [tmu_pkg::DIFF_W-1:0]       y_q_o,
	output logic [tmu_pkg::DIFF_W-1:0]       y_r_o
);
	import tmu_pkg::*;

	logic running;
	logic [4:0] cnt;
	logic [RES_W-1:0] div_w;

	// one restoring step, returns {remainder, quotient}.
	function automatic logic [2*DIFF_W-1:0] div_step(input logic [DIFF_W-1:0] r,
			input logic [DIFF_W-1:0] q, input logic [RES_W-1:0] d);
		logic [DIFF_W:0] trial;
		trial = {r, q[DIFF_W-1]} - {{(DIFF_W+1-RES_W){1'b0}}, d};
		if (trial[DIFF_W])
			return {r[DIFF_W-2:0], q[DIFF_W-1], q[DIFF_W-2:0], 1'b0};
		return {trial[DIFF_W-1:0], q[DIFF_W-2:0], 1'b1};
	endfunction

	assign busy_o = running | pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			running <= 1'b0;
			pipe_stb_o <= 1'b0;
			cnt <= '0;
		end else if (start_i) begin
			running <= 1'b1;
			cnt <= 5'(DIV_STEPS);
		end else if (running) begin
			cnt <= cnt - 5'd1;
			if (cnt == 5'd1) begin
				running <= 1'b0;
				pipe_stb_o <= 1'b1;
			end
		end else if (pipe_ack_i)
			pipe_stb_o <= 1'b0;
	end

	// quotient builds up in place of the dividend.
	always_ff @(posedge sys_clk) begin
		if (start_i) begin
			ts_x_o <= ts_x_i;
			ts_y_o <= ts_y_i;
			div_w <= span_w_i;
			x_pos_o <= te_x_i >= ts_x_i;
			y_pos_o <= te_y_i >= ts_y_i;
			x_q_o <= (te_x_i >= ts_x_i) ? DIFF_W'(te_x_i - ts_x_i) : DIFF_W'(ts_x_i - te_x_i);
			y_q_o <= (te_y_i >= ts_y_i) ? DIFF_W'(te_y_i - ts_y_i) : DIFF_W'(ts_y_i - te_y_i);
			x_r_o <= '0;
			y_r_o <= '0;
		end else if (running) begin
			{x_r_o, x_q_o} <= div_step(x_r_o, x_q_o, div_w);
			{y_r_o, y_q_o} <= div_step(y_r_o, y_q_o, div_w);
		end
	end

endmodule

//--- tmu_hinterp.sv
// horizontal interpolator, steps destination x and texture coordinates per pixel.
`timescale 1ns/1ps

module tmu_hinterp (
	input  logic                              sys_clk,
	input  logic                              sys_rst,
	input  logic                              pipe_stb_i,
	output logic                              pipe_ack_o,
	input  logic signed [tmu_pkg::FP_W-1:0]   ts_x_i,
	input  logic signed [tmu_pkg::FP_W-1:0]   ts_y_i,
	input  logic                              x_pos_i,
	input  logic [tmu_pkg::DIFF_W-1:0]        x_q_i,
	input  logic [tmu_pkg::DIFF_W-1:0]        x_r_i,
	input  logic                              y_pos_i,
	input  logic [tmu_pkg::DIFF_W-1:0]        y_q_i,
	input  logic [tmu_pkg::DIFF_W-1:0]        y_r_i,
	input  logic [tmu_pkg::RES_W-1:0]         span_w_i,
	input  logic signed [tmu_pkg::PIX_W-1:0]  dst_x_i,
	input  logic signed [tmu_pkg::PIX_W-1:0]  dst_y_i,
	output logic                              busy_o,
	output logic                              pipe_stb_o,
	input  logic                              pipe_ack_i,
	output logic signed [tmu_pkg::PIX_W-1:0]  dx_o,
	output logic signed [tmu_pkg::PIX_W-1:0]  dy_o,
	output logic signed [tmu_pkg::FP_W-1:0]   tx_o,
	output logic signed [tmu_pkg::FP_W-1:0]   ty_o
);
	import tmu_pkg::*;

	logic [RES_W-1:0] remaining;
	logic x_pos, y_pos;
	logic [DIFF_W-1:0] x_q, x_r, y_q, y_r;
	logic [DIFF_W-1:0] err_x, err_y, err_x_next, err_y_next;
	logic [FP_W-1:0] tx_next, ty_next;

	// quotient step plus one more unit when the error wraps, returns {t, err}.
	function automatic logic [FP_W+DIFF_W-1:0] step_axis(input logic [FP_W-1:0] t,
			input logic pos, input logic [DIFF_W-1:0] q, input logic [DIFF_W-1:0] r,
			input logic [DIFF_W-1:0] err, input logic [RES_W-1:0] w);
		logic [DIFF_W-1:0] e;
		logic [FP_W-1:0] inc;
		e = err + r;
		inc = {1'b0, q};
		if (e >= DIFF_W'(w)) begin
			e = e - DIFF_W'(w);
			inc = inc + FP_W'(1);
		end
		return {pos ? t + inc : t - inc, e};
	endfunction

	assign {tx_next, err_x_next} = step_axis(tx_o, x_pos, x_q, x_r, err_x, span_w_i);
	assign {ty_next, err_y_next} = step_axis(ty_o, y_pos, y_q, y_r, err_y, span_w_i);
	assign pipe_ack_o = ~pipe_stb_o;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			remaining <= '0;
		end else if (pipe_stb_i & pipe_ack_o) begin
			// an empty span emits nothing.
			pipe_stb_o <= span_w_i != '0;
			remaining <= span_w_i;
		end else if (pipe_stb_o & pipe_ack_i) begin
			remaining <= remaining - RES_W'(1);
			if (remaining == RES_W'(1))
				pipe_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i & pipe_ack_o) begin
			{x_pos, x_q, x_r} <= {x_pos_i, x_q_i, x_r_i};
			{y_pos, y_q, y_r} <= {y_pos_i, y_q_i, y_r_i};
			err_x <= '0;
			err_y <= '0;
			dx_o <= dst_x_i;
			dy_o <= dst_y_i;
			tx_o <= ts_x_i;
			ty_o <= ts_y_i;
		end else if (pipe_stb_o & pipe_ack_i) begin
			err_x <= err_x_next;
			err_y <= err_y_next;
			dx_o <= dx_o + PIX_W'(1);
			tx_o <= tx_next;
			ty_o <= ty_next;
		end
	end

endmodule

//--- tmu_adrgen.sv
// address generator, wraps texture coordinates, drops off-screen pixels, builds addresses.
`timescale 1ns/1ps

module tmu_adrgen (
	input  logic                              sys_clk,
	input  logic                              sys_rst,
	input  logic                              pipe_stb_i,
	output logic                              pipe_ack_o,
	input  logic signed [tmu_pkg::PIX_W-1:0]  dx_i,
	input  logic signed [tmu_pkg::PIX_W-1:0]  dy_i,
	input  logic signed [tmu_pkg::FP_W-1:0]   tx_i,
	input  logic signed [tmu_pkg::FP_W-1:0]   ty_i,
	input  logic [tmu_pkg::FP_W-1:0]          tex_hmask_i,
	input  logic [tmu_pkg::FP_W-1:0]          tex_vmask_i,
	input  logic [tmu_pkg::ADR_W-1:0]         tex_fbuf_i,
	input  logic [tmu_pkg::RES_W-1:0]         tex_hres_i,
	input  logic [tmu_pkg::ADR_W-1:0]         dst_fbuf_i,
	input  logic [tmu_pkg::RES_W-1:0]         dst_hres_i,
	output logic                              busy_o,
	output logic                              pipe_stb_o,
	input  logic                              pipe_ack_i,
	output logic [tmu_pkg::ADR_W-1:0]         tadr_o,
	output logic [tmu_pkg::ADR_W-1:0]         dadr_o
);
	import tmu_pkg::*;

	logic [FP_W-1:0] tx_m, ty_m;
	logic [RES_W-1:0] tx_int, ty_int;
	logic visible;

	// integer part of the wrapped coordinate.
	assign tx_m = tx_i & tex_hmask_i;
	assign ty_m = ty_i & tex_vmask_i;
	assign tx_int = tx_m[FP_W-2:FP_FRAC];
	assign ty_int = ty_m[FP_W-2:FP_FRAC];

	assign visible = ~dx_i[PIX_W-1] & ~dy_i[PIX_W-1] & (dx_i[RES_W-1:0] < dst_hres_i);
	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pipe_stb_o <= 1'b0;
		else if (pipe_ack_o)
			pipe_stb_o <= pipe_stb_i & visible;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_ack_o) begin
			tadr_o <= tex_fbuf_i + ADR_W'(ty_int) * ADR_W'(tex_hres_i) + ADR_W'(tx_int);
			dadr_o <= dst_fbuf_i + ADR_W'(dy_i[RES_W-1:0]) * ADR_W'(dst_hres_i)
				+ ADR_W'(dx_i[RES_W-1:0]);
		end
	end

endmodule

//--- tmu_pixout.sv
// pixel output, reads the texel, applies chroma key and brightness, writes the pixel.
`timescale 1ns/1ps

module tmu_pixout (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  logic                          pipe_stb_i,
	output logic                          pipe_ack_o,
	input  logic [tmu_pkg::ADR_W-1:0]     tadr_i,
	input  logic [tmu_pkg::ADR_W-1:0]     dadr_i,
	input  logic [tmu_pkg::BRIGHT_W-1:0]  brightness_i,
	input  logic                          chroma_key_en_i,
	input  tmu_pkg::pixel_t               chroma_key_i,
	output logic                          busy_o,
	output logic [tmu_pkg::ADR_W-1:0]     tex_adr_o,
	output logic                          tex_stb_o,
	input  logic                          tex_ack_i,
	input  tmu_pkg::pixel_t               tex_dat_i,
	output logic [tmu_pkg::ADR_W-1:0]     pix_adr_o,
	output tmu_pkg::pixel_t               pix_dat_o,
	output logic                          pix_stb_o,
	input  logic                          pix_ack_i
);
	import tmu_pkg::*;

	logic [1:0] state;
	logic [BRIGHT_W:0] scale;
	logic [11:0] r_mul, g_mul, b_mul;
	logic key_hit;
	pixel_t decayed;

	// upstream holds the addresses until the pixel is acknowledged.
	assign tex_adr_o = tadr_i;
	assign pix_adr_o = dadr_i;

	assign key_hit = chroma_key_en_i & (tex_dat_i.raw == chroma_key_i.raw);

	// channel * (brightness + 1) / 64, truncated.
	assign scale = {1'b0, brightness_i} + 7'd1;
	assign r_mul = {7'd0, tex_dat_i.rgb.r} * {5'd0, scale};
	assign g_mul = {6'd0, tex_dat_i.rgb.g} * {5'd0, scale};
	assign b_mul = {7'd0, tex_dat_i.rgb.b} * {5'd0, scale};
	assign decayed.rgb.r = r_mul[BRIGHT_W+4:BRIGHT_W];
	assign decayed.rgb.g = g_mul[BRIGHT_W+5:BRIGHT_W];
	assign decayed.rgb.b = b_mul[BRIGHT_W+4:BRIGHT_W];

	assign pipe_ack_o = ((state == PIX_READ) & tex_ack_i & key_hit)
		| ((state == PIX_WRITE) & pix_ack_i);
	assign busy_o = state != PIX_IDLE;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= PIX_IDLE;
			tex_stb_o <= 1'b0;
			pix_stb_o <= 1'b0;
		end else begin
			case (state)
				PIX_IDLE: if (pipe_stb_i) begin
					state <= PIX_READ;
					tex_stb_o <= 1'b1;
				end
				PIX_READ: if (tex_ack_i) begin
					tex_stb_o <= 1'b0;
					if (key_hit)
						state <= PIX_IDLE;
					else begin
						state <= PIX_WRITE;
						pix_stb_o <= 1'b1;
					end
				end
				PIX_WRITE: if (pix_ack_i) begin
					pix_stb_o <= 1'b0;
					state <= PIX_IDLE;
				end
				default: state <= PIX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if ((state == PIX_READ) & tex_ack_i)
			pix_dat_o <= decayed;
	end

endmodule

//--- tmu_top.sv
// texture mapping unit top level, stage chain and span busy FSM.
`timescale 1ns/1ps

module tmu_top (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  logic [tmu_pkg::CSR_AW-1:0]  csr_a_i,
	input  logic                        csr_we_i,
	input  logic [31:0]                 csr_di_i,
	output logic [31:0]                 csr_do_o,
	output logic                        irq_o,
	output logic [tmu_pkg::ADR_W-1:0]   tex_adr_o,
	output logic                        tex_stb_o,
	input  logic                        tex_ack_i,
	input  tmu_pkg::pixel_t             tex_dat_i,
	output logic [tmu_pkg::ADR_W-1:0]   pix_adr_o,
	output tmu_pkg::pixel_t             pix_dat_o,
	output logic                        pix_stb_o,
	input  logic                        pix_ack_i
);
	import tmu_pkg::*;

	logic start, busy, state;
	logic [BRIGHT_W-1:0] brightness;
	logic chroma_key_en;
	pixel_t chroma_key;
	logic [ADR_W-1:0] tex_fbuf, dst_fbuf;
	logic [RES_W-1:0] tex_hres, dst_hres, span_w;
	logic [FP_W-1:0] tex_hmask, tex_vmask;
	logic signed [PIX_W-1:0] dst_x, dst_y;
	logic signed [FP_W-1:0] ts_x, ts_y, te_x, te_y;

	tmu_ctlif i_ctlif (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
		.irq_o(irq_o), .start_o(start), .busy_i(busy),
		.brightness_o(brightness), .chroma_key_en_o(chroma_key_en),
		.chroma_key_o(chroma_key), .tex_fbuf_o(tex_fbuf), .tex_hres_o(tex_hres),
		.tex_hmask_o(tex_hmask), .tex_vmask_o(tex_vmask), .dst_fbuf_o(dst_fbuf),
		.dst_hres_o(dst_hres), .dst_x_o(dst_x), .dst_y_o(dst_y), .span_w_o(span_w),
		.ts_x_o(ts_x), .ts_y_o(ts_y), .te_x_o(te_x), .te_y_o(te_y)
	);

	// stage 1, division of the deltas.
	logic hdiv_busy, hdiv_stb, hdiv_ack, x_pos, y_pos;
	logic signed [FP_W-1:0] hdiv_ts_x, hdiv_ts_y;
	logic [DIFF_W-1:0] x_q, x_r, y_q, y_r;

	tmu_hdiv i_hdiv (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .start_i(start),
		.ts_x_i(ts_x), .ts_y_i(ts_y), .te_x_i(te_x), .te_y_i(te_y), .span_w_i(span_w),
		.busy_o(hdiv_busy), .pipe_stb_o(hdiv_stb), .pipe_ack_i(hdiv_ack),
		.ts_x_o(hdiv_ts_x), .ts_y_o(hdiv_ts_y),
		.x_pos_o(x_pos), .x_q_o(x_q), .x_r_o(x_r),
		.y_pos_o(y_pos), .y_q_o(y_q), .y_r_o(y_r)
	);

	// stage 2, per-pixel interpolation.
	logic hinterp_busy, hinterp_stb, hinterp_ack;
	logic signed [PIX_W-1:0] dx, dy;
	logic signed [FP_W-1:0] tx, ty;

	tmu_hinterp i_hinterp (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pipe_stb_i(hdiv_stb), .pipe_ack_o(hdiv_ack),
		.ts_x_i(hdiv_ts_x), .ts_y_i(hdiv_ts_y),
		.x_pos_i(x_pos), .x_q_i(x_q), .x_r_i(x_r),
		.y_pos_i(y_pos), .y_q_i(y_q), .y_r_i(y_r),
		.span_w_i(span_w), .dst_x_i(dst_x), .dst_y_i(dst_y),
		.busy_o(hinterp_busy), .pipe_stb_o(hinterp_stb), .pipe_ack_i(hinterp_ack),
		.dx_o(dx), .dy_o(dy), .tx_o(tx), .ty_o(ty)
	);

	// stage 3, wrap, clip and addresses.
	logic adrgen_busy, adrgen_stb, adrgen_ack;
	logic [ADR_W-1:0] tadr, dadr;

	tmu_adrgen i_adrgen (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pipe_stb_i(hinterp_stb), .pipe_ack_o(hinterp_ack),
		.dx_i(dx), .dy_i(dy), .tx_i(tx), .ty_i(ty),
		.tex_hmask_i(tex_hmask), .tex_vmask_i(tex_vmask),
		.tex_fbuf_i(tex_fbuf), .tex_hres_i(tex_hres),
		.dst_fbuf_i(dst_fbuf), .dst_hres_i(dst_hres),
		.busy_o(adrgen_busy), .pipe_stb_o(adrgen_stb), .pipe_ack_i(adrgen_ack),
		.tadr_o(tadr), .dadr_o(dadr)
	);

	// stage 4, texel read and pixel write.
	logic pixout_busy;

	tmu_pixout i_pixout (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pipe_stb_i(adrgen_stb), .pipe_ack_o(adrgen_ack), .tadr_i(tadr), .dadr_i(dadr),
		.brightness_i(brightness), .chroma_key_en_i(chroma_key_en),
		.chroma_key_i(chroma_key), .busy_o(pixout_busy),
		.tex_adr_o(tex_adr_o), .tex_stb_o(tex_stb_o),
		.tex_ack_i(tex_ack_i), .tex_dat_i(tex_dat_i),
		.pix_adr_o(pix_adr_o), .pix_dat_o(pix_dat_o),
		.pix_stb_o(pix_stb_o), .pix_ack_i(pix_ack_i)
	);

	// span stays busy until every stage has drained.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= TOP_IDLE;
		else if (state == TOP_IDLE) begin
			if (start)
				state <= TOP_PROCESS;
		end else if (~(hdiv_busy | hinterp_busy | adrgen_busy | pixout_busy))
			state <= TOP_IDLE;
	end

	assign busy = state == TOP_PROCESS;

endmodule

//--- tb_tmu.sv
// texture mapping unit testbench with memory models and directed span tests.
`timescale 1ns/1ps

module tb_tmu;
	import tmu_pkg::*;

	// six tests take well under two thousand cycles even with random ack delays.
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic sys_clk;
	logic sys_rst;
	logic [CSR_AW-1:0] csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i;
	logic [31:0] csr_do_o;
	logic irq_o;
	logic [ADR_W-1:0] tex_adr_o;
	logic [ADR_W-1:0] pix_adr_o;
	logic tex_stb_o;
	logic tex_ack_i;
	logic pix_stb_o;
	logic pix_ack_i;
	pixel_t tex_dat_i;
	pixel_t pix_dat_o;

	logic [31:0] lfsr;
	logic ack_delay_en;
	int cycle_count;
	int irq_count;
	int tex_wait;
	int pix_wait;
	logic [ADR_W-1:0] exp_tadr[$];
	logic [ADR_W-1:0] exp_dadr[$];
	pixel_t exp_pix[$];

	// span set-up shared by the register writes and the model.
	int cfg_bright, cfg_tex_fbuf, cfg_tex_hres, cfg_hmask, cfg_vmask;
	int cfg_dst_fbuf, cfg_dst_hres, cfg_dst_x, cfg_dst_y, cfg_span_w;
	int cfg_ts_x, cfg_ts_y, cfg_te_x, cfg_te_y;

	tmu_top i_tmu_top (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a_i(csr_a_i), .csr_we_i(csr_we_i), .csr_di_i(csr_di_i), .csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.tex_adr_o(tex_adr_o), .tex_stb_o(tex_stb_o),
		.tex_ack_i(tex_ack_i), .tex_dat_i(tex_dat_i),
		.pix_adr_o(pix_adr_o), .pix_dat_o(pix_dat_o),
		.pix_stb_o(pix_stb_o), .pix_ack_i(pix_ack_i)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ LFSR_TAPS : s >> 1;
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// coordinate of pixel i is the start plus i/w of the delta, rounded toward the start.
	function automatic int coord_at(input int ts, input int te, input int i);
		int mag;
		mag = (te >= ts) ? te - ts : ts - te;
		return (te >= ts) ? ts + (i * mag) / cfg_span_w : ts - (i * mag) / cfg_span_w;
	endfunction

	function automatic int texel_index(input int t, input int mask);
		return ((t & mask) >> FP_FRAC) & 32'h7FF;
	endfunction

	function automatic logic [ADR_W-1:0] texel_addr(input int i);
		int ux;
		int uy;
		ux = texel_index(coord_at(cfg_ts_x, cfg_te_x, i), cfg_hmask);
		uy = texel_index(coord_at(cfg_ts_y, cfg_te_y, i), cfg_vmask);
		return ADR_W'(cfg_tex_fbuf + uy * cfg_tex_hres + ux);
	endfunction

	// texel model folds the whole address into a fixed pattern.
	function automatic pixel_t texel_at(input logic [ADR_W-1:0] a);
		pixel_t p;
		p.raw = a[15:0] ^ {8'h00, a[ADR_W-1:16]} ^ 16'h5A5A;
		return p;
	endfunction

	function automatic pixel_t decay(input pixel_t p, input int bright);
		pixel_t d;
		d.rgb.r = 5'((int'(p.rgb.r) * (bright + 1)) / 64);
		d.rgb.g = 6'((int'(p.rgb.g) * (bright + 1)) / 64);
		d.rgb.b = 5'((int'(p.rgb.b) * (bright + 1)) / 64);
		return d;
	endfunction

	function automatic logic [31:0] readback_of(input logic [CSR_AW-1:0] a,
			input logic [31:0] v);
		int w;
		logic sgn;
		logic [31:0] m;
		sgn = 1'b0;
		case (a)
			REG_BRIGHT: w = BRIGHT_W;
			REG_CKEY: w = 16;
			REG_TEX_FBUF, REG_DST_FBUF: w = ADR_W;
			REG_TEX_HRES, REG_DST_HRES, REG_SPAN_W: w = RES_W;
			REG_TEX_HMASK, REG_TEX_VMASK: w = FP_W;
			REG_DST_X, REG_DST_Y: begin
				w = PIX_W;
				sgn = 1'b1;
			end
			default: begin
				w = FP_W;
				sgn = 1'b1;
			end
		endcase
		m = (32'd1 << w) - 32'd1;
		// coordinates come back sign extended.
		if (sgn && v[w-1])
			return (v & m) | ~m;
		return v & m;
	endfunction

	task automatic report_failure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_addr(input logic [ADR_W-1:0] got, input logic [ADR_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		if (got.raw !== exp.raw) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got.raw,
				exp.raw);
			$display("TB FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	// both memory ports ack with a one-cycle pulse after an optional delay.
	initial begin
		lfsr = 32'd65792;
		irq_count = 0;
		tex_wait = -1;
		pix_wait = -1;
		tex_ack_i = 1'b0;
		pix_ack_i = 1'b0;
		tex_dat_i = '0;
		forever begin
			@(posedge sys_clk);
			#1;
			if (irq_o)
				irq_count++;
			if (tex_ack_i)
				tex_ack_i = 1'b0;
			else if (tex_stb_o) begin
				if (tex_wait < 0)
					tex_wait = ack_delay_en ? take_bits(2) : 0;
				if (tex_wait > 0)
					tex_wait--;
				else begin
					tex_wait = -1;
					tex_dat_i = texel_at(tex_adr_o);
					tex_ack_i = 1'b1;
					if (exp_tadr.size() == 0)
						report_failure("texel read that the model does not expect");
					else
						check_addr(tex_adr_o, exp_tadr.pop_front(), "texel read address");
				end
			end
			if (pix_ack_i)
				pix_ack_i = 1'b0;
			else if (pix_stb_o) begin
				if (pix_wait < 0)
					pix_wait = ack_delay_en ? take_bits(2) : 0;
				if (pix_wait > 0)
					pix_wait--;
				else begin
					pix_wait = -1;
					pix_ack_i = 1'b1;
					if (exp_dadr.size() == 0)
						report_failure("pixel write that the model does not expect");
					else begin
						check_addr(pix_adr_o, exp_dadr.pop_front(), "pixel write address");
						check_pixel(pix_dat_o, exp_pix.pop_front(), "pixel write data");
					end
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, a span never finished", cycle_count);
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	task automatic write_reg(input logic [CSR_AW-1:0] a, input logic [31:0] d);
		csr_a_i = a;
		csr_di_i = d;
		csr_we_i = 1'b1;
		@(posedge sys_clk);
		#1;
		csr_we_i = 1'b0;
	endtask

	task automatic read_reg(input logic [CSR_AW-1:0] a, output logic [31:0] d);
		csr_a_i = a;
		@(posedge sys_clk);
		#1;
		d = csr_do_o;
	endtask

	// queue up the texel reads and pixel writes the span should produce.
	task automatic expect_span(input logic key_en, input pixel_t key);
		int dx;
		logic [ADR_W-1:0] ta;
		pixel_t tex;
		for (int i = 0; i < cfg_span_w; i++) begin
			dx = cfg_dst_x + i;
			ta = texel_addr(i);
			tex = texel_at(ta);
			if (dx >= 0 && cfg_dst_y >= 0 && dx < cfg_dst_hres) begin
				exp_tadr.push_back(ta);
				if (!(key_en && tex.raw == key.raw)) begin
					exp_dadr.push_back(ADR_W'(cfg_dst_fbuf + cfg_dst_y * cfg_dst_hres + dx));
					exp_pix.push_back(decay(tex, cfg_bright));
				end
			end
		end
	endtask

	task automatic run_span(input logic key_en, input pixel_t key);
		int irq_before;
		logic [31:0] rd;
		write_reg(REG_BRIGHT, cfg_bright);
		write_reg(REG_CKEY, {16'd0, key.raw});
		write_reg(REG_TEX_FBUF, cfg_tex_fbuf);
		write_reg(REG_TEX_HRES, cfg_tex_hres);
		write_reg(REG_TEX_HMASK, cfg_hmask);
		write_reg(REG_TEX_VMASK, cfg_vmask);
		write_reg(REG_DST_FBUF, cfg_dst_fbuf);
		write_reg(REG_DST_HRES, cfg_dst_hres);
		write_reg(REG_DST_X, cfg_dst_x);
		write_reg(REG_DST_Y, cfg_dst_y);
		write_reg(REG_SPAN_W, cfg_span_w);
		write_reg(REG_TS_X, cfg_ts_x);
		write_reg(REG_TS_Y, cfg_ts_y);
		write_reg(REG_TE_X, cfg_te_x);
		write_reg(REG_TE_Y, cfg_te_y);
		expect_span(key_en, key);
		irq_before = irq_count;
		write_reg(REG_CTRL, {30'd0, key_en, 1'b1});
		while (irq_o !== 1'b1) begin
			@(posedge sys_clk);
			#1;
		end
		repeat (4) @(posedge sys_clk);
		#1;
		if (exp_tadr.size() != 0 || exp_dadr.size() != 0)
			report_failure("span ended with texel reads or pixel writes still missing");
		else if (irq_count - irq_before != 1)
			report_failure("the interrupt did not pulse exactly once for the span");
		read_reg(REG_CTRL, rd);
		check_word(rd, {30'd0, key_en, 1'b0}, "CTRL after the span");
	endtask

	task automatic readback_after_reset();
		logic [31:0] rd;
		logic [31:0] val;
		if (irq_o !== 1'b0)
			report_failure("irq_o is not low after reset");
		read_reg(REG_CTRL, rd);
		check_word(rd, 32'd0, "CTRL after reset");
		for (int idx = 1; idx < 16; idx++) begin
			val = 32'h9E37_79B9 * (idx + 1);
			write_reg(CSR_AW'(idx), val);
			read_reg(CSR_AW'(idx), rd);
			check_word(rd, readback_of(CSR_AW'(idx), val),
				$sformatf("register %0d readback", idx));
		end
	endtask

	// 8 pixels with x stepping 2.5 texels and y about 0.29 texels per pixel.
	task automatic set_forward_span();
		cfg_bright = 63;
		cfg_tex_fbuf = 'h1000;
		cfg_tex_hres = 64;
		cfg_hmask = 'h3FFFF;
		cfg_vmask = 'h3FFFF;
		cfg_dst_fbuf = 'h20000;
		cfg_dst_hres = 320;
		cfg_dst_x = 100;
		cfg_dst_y = 50;
		cfg_span_w = 8;
		cfg_ts_x = 10 * 64;
		cfg_te_x = 30 * 64;
		cfg_ts_y = 5 * 64;
		cfg_te_y = 7 * 64 + 20;
	endtask

	task automatic forward_span();
		set_forward_span();
		run_span(1'b0, '0);
	endtask

	task automatic decreasing_span();
		set_forward_span();
		cfg_bright = 31;
		cfg_tex_fbuf = 'h4000;
		cfg_tex_hres = 100;
		cfg_dst_fbuf = 'h30000;
		cfg_dst_x = 10;
		cfg_dst_y = 7;
		cfg_span_w = 11;
		cfg_ts_x = 40 * 64;
		cfg_te_x = 13 * 64 + 7;
		cfg_ts_y = 20 * 64;
		cfg_te_y = 3 * 64;
		run_span(1'b0, '0);
	endtask

	// key equals the texel of pixel 3 and no other texel in the span.
	task automatic chroma_key_skip();
		set_forward_span();
		run_span(1'b1, texel_at(texel_addr(3)));
	endtask

	// pixels 0 to 2 lie left of the screen and 9 to 11 beyond dst_hres with an 8 by 4 wrap.
	task automatic clip_and_wrap();
		cfg_bright = 63;
		cfg_tex_fbuf = 'h8000;
		cfg_tex_hres = 16;
		cfg_hmask = 'h1FF;
		cfg_vmask = 'h0FF;
		cfg_dst_fbuf = 'h40000;
		cfg_dst_hres = 6;
		cfg_dst_x = -3;
		cfg_dst_y = 2;
		cfg_span_w = 12;
		cfg_ts_x = 20 * 64;
		cfg_te_x = 44 * 64;
		cfg_ts_y = 9 * 64;
		cfg_te_y = 13 * 64;
		run_span(1'b0, '0);
	endtask

	// forward span again under random ack delays.
	task automatic back_pressure_span();
		ack_delay_en = 1'b1;
		set_forward_span();
		run_span(1'b0, '0);
		ack_delay_en = 1'b0;
	endtask

	initial begin
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		ack_delay_en = 1'b0;
		repeat (5) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		readback_after_reset();
		forward_span();
		decreasing_span();
		chroma_key_skip();
		clip_and_wrap();
		back_pressure_span();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- tmu.f
tmu_pkg.sv
tmu_ctlif.sv
tmu_hdiv.sv
tmu_hinterp.sv
tmu_adrgen.sv
tmu_pixout.sv
tmu_top.sv
tb_tmu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= tb_tmu
FILELIST ?= tmu.f
OBJ_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
